/* hw/packet_pkg.sv */
`default_nettype none

package packet_pkg;

    // ==================================================
    // Beat geometry
    // ==================================================
    localparam int DATA_BYTE_WID = 8;
    localparam int MTY_WID = 3;
    localparam int META_WID = 32;

    // ==================================================
    // Buffer sizing
    // ==================================================
    localparam int FIFO_DEPTH = 64;
    localparam int FIFO_ADDR_WID = 6;

    // Extra MSB tells full from empty
    localparam int PTR_WID = FIFO_ADDR_WID + 1;

    // Forwarded and dropped packet counters
    localparam int CNT_WID = 16;

    // One bus beat with byte 0 in the top byte of data
    typedef struct packed {
        logic [DATA_BYTE_WID*8-1:0] data;
        logic                       eop;
        logic [MTY_WID-1:0]         mty;
        logic                       err;
        logic [META_WID-1:0]        meta;
    } packet_beat_t;

    // Write side of the packet FIFO
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_DISCARD
    } wr_state_e;

endpackage

`default_nettype wire

/* hw/packet_intf_connector.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_intf_connector (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     in_valid,
    output logic                          in_ready,
    input  wire packet_pkg::packet_beat_t in_beat,
    output logic                          out_valid,
    input  wire logic                     out_ready,
    output packet_pkg::packet_beat_t      out_beat
);

    // Skid entry catches the beat in flight when the output stalls
    packet_pkg::packet_beat_t skid_beat;

    logic in_xfer;
    logic out_free;

    assign in_xfer = in_valid && in_ready;

    // Main register can take a new beat this cycle
    assign out_free = !out_valid || out_ready;

    // ==================================================
    // Valid and ready flags
    // ==================================================
    // in_ready low means the skid entry is occupied
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end else if (out_free) begin
            out_valid <= !in_ready || in_xfer;
            in_ready  <= 1'b1;
        end else if (in_xfer) begin
            in_ready <= 1'b0;
        end
    end

    // ==================================================
    // Payload registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (out_free) begin
            // Drain the skid entry first to keep beat order
            if (!in_ready) begin
                out_beat <= skid_beat;
            end else if (in_xfer) begin
                out_beat <= in_beat;
            end
        end else if (in_xfer) begin
            skid_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

/* hw/packet_fifo_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_fifo_mem (
    input  wire logic                                clk,
    input  wire logic                                wr_en,
    input  wire logic [packet_pkg::FIFO_ADDR_WID-1:0] wr_addr,
    input  wire packet_pkg::packet_beat_t            wr_beat,
    input  wire logic                                rd_en,
    input  wire logic [packet_pkg::FIFO_ADDR_WID-1:0] rd_addr,
    output packet_pkg::packet_beat_t                 rd_beat
);

    // Beat storage, one word per beat
    packet_pkg::packet_beat_t mem [packet_pkg::FIFO_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // Registered read port
    // holds its last word while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/packet_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_fifo (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       in_valid,
    output logic                            in_ready,
    input  wire packet_pkg::packet_beat_t   in_beat,
    output logic                            out_valid,
    input  wire logic                       out_ready,
    output packet_pkg::packet_beat_t        out_beat,
    output logic [packet_pkg::CNT_WID-1:0]  pkt_count,
    output logic [packet_pkg::CNT_WID-1:0]  drop_count
);

    // Pointers carry one extra wrap bit
    logic [packet_pkg::PTR_WID-1:0] wr_ptr;
    logic [packet_pkg::PTR_WID-1:0] commit_ptr;
    logic [packet_pkg::PTR_WID-1:0] rd_ptr;

    packet_pkg::wr_state_e wr_state;

    logic in_xfer;
    logic full;
    logic wr_en;
    logic rd_en;
    logic out_xfer;

    // ==================================================
    // Write side
    // ==================================================

    // Drops replace back-pressure, so every beat is taken
    assign in_ready = 1'b1;

    assign in_xfer = in_valid && in_ready;

    // Full when write has lapped the read pointer once
    assign full = (wr_ptr[packet_pkg::FIFO_ADDR_WID] != rd_ptr[packet_pkg::FIFO_ADDR_WID]) &&
                  (wr_ptr[packet_pkg::FIFO_ADDR_WID-1:0] ==
                   rd_ptr[packet_pkg::FIFO_ADDR_WID-1:0]);

    // Beats are stored unless the packet is already condemned
    assign wr_en = in_xfer && !full && (wr_state != packet_pkg::ST_DISCARD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state   <= packet_pkg::ST_IDLE;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            drop_count <= '0;
        end else if (in_xfer) begin
            case (wr_state)
                packet_pkg::ST_IDLE,
                packet_pkg::ST_WRITE: begin
                    if (full) begin
                        // Out of room mid-packet so the stored beats are thrown away
                        wr_ptr <= commit_ptr;
                        if (in_beat.eop) begin
                            drop_count <= drop_count + 1'b1;
                            wr_state   <= packet_pkg::ST_IDLE;
                        end else begin
                            wr_state <= packet_pkg::ST_DISCARD;
                        end
                    end else if (in_beat.eop) begin
                        wr_state <= packet_pkg::ST_IDLE;
                        if (in_beat.err) begin
                            // Bad packet rewinds to the last good boundary
                            wr_ptr     <= commit_ptr;
                            drop_count <= drop_count + 1'b1;
                        end else begin
                            wr_ptr     <= wr_ptr + 1'b1;
                            commit_ptr <= wr_ptr + 1'b1;
                        end
                    end else begin
                        wr_ptr   <= wr_ptr + 1'b1;
                        wr_state <= packet_pkg::ST_WRITE;
                    end
                end

                packet_pkg::ST_DISCARD: begin
                    // Swallow the rest of the packet
                    if (in_beat.eop) begin
                        drop_count <= drop_count + 1'b1;
                        wr_state   <= packet_pkg::ST_IDLE;
                    end
                end

                default: begin
                    wr_state <= packet_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // Read side
    // ==================================================

    // The memory read register doubles as the output stage.
    // A new word is fetched whenever that stage is empty or moving.
    assign rd_en = (rd_ptr != commit_ptr) && (!out_valid || out_ready);

    assign out_xfer = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else if (rd_en) begin
            rd_ptr    <= rd_ptr + 1'b1;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Forwarded packets are counted as their last beat leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_count <= '0;
        end else if (out_xfer && out_beat.eop) begin
            pkt_count <= pkt_count + 1'b1;
        end
    end

    // ==================================================
    // Beat storage
    // ==================================================
    packet_fifo_mem mem_inst (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_ptr[packet_pkg::FIFO_ADDR_WID-1:0]),
        .wr_beat (in_beat),
        .rd_en   (rd_en),
        .rd_addr (rd_ptr[packet_pkg::FIFO_ADDR_WID-1:0]),
        .rd_beat (out_beat)
    );

endmodule

`default_nettype wire

/* hw/packet_buffer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_buffer_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       in_valid,
    output logic                            in_ready,
    input  wire packet_pkg::packet_beat_t   in_beat,
    output logic                            out_valid,
    input  wire logic                       out_ready,
    output packet_pkg::packet_beat_t        out_beat,
    output logic [packet_pkg::CNT_WID-1:0]  pkt_count,
    output logic [packet_pkg::CNT_WID-1:0]  drop_count
);

    // Input slice to FIFO
    logic                     fifo_in_valid;
    logic                     fifo_in_ready;
    packet_pkg::packet_beat_t fifo_in_beat;

    // FIFO to output slice
    logic                     fifo_out_valid;
    logic                     fifo_out_ready;
    packet_pkg::packet_beat_t fifo_out_beat;

    packet_intf_connector connector_in (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (fifo_in_valid),
        .out_ready (fifo_in_ready),
        .out_beat  (fifo_in_beat)
    );

    packet_fifo fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (fifo_in_valid),
        .in_ready   (fifo_in_ready),
        .in_beat    (fifo_in_beat),
        .out_valid  (fifo_out_valid),
        .out_ready  (fifo_out_ready),
        .out_beat   (fifo_out_beat),
        .pkt_count  (pkt_count),
        .drop_count (drop_count)
    );

    packet_intf_connector connector_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fifo_out_valid),
        .in_ready  (fifo_out_ready),
        .in_beat   (fifo_out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

endmodule

`default_nettype wire

/* test/packet_buffer_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_buffer_checker (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           in_valid,
    input  wire logic                           in_ready,
    input  wire packet_pkg::packet_beat_t       in_beat,
    input  wire logic                           out_valid,
    input  wire logic                           out_ready,
    input  wire packet_pkg::packet_beat_t       out_beat,
    input  wire logic [packet_pkg::CNT_WID-1:0] pkt_count,
    input  wire logic [packet_pkg::CNT_WID-1:0] drop_count,
    input  wire logic                           check_counters,
    output int                                  pending_beats,
    output int                                  beat_errors,
    output int                                  count_errors,
    output int                                  other_errors
);

    // Beats owed at the output in arrival order
    packet_pkg::packet_beat_t exp_q [$];
    // Packet being collected at the input
    packet_pkg::packet_beat_t cur_pkt [$];
    packet_pkg::packet_beat_t exp_beat;
    packet_pkg::packet_beat_t held_beat;

    logic stalled;
    logic counters_checked;
    int   occupancy;
    int   out_beat_idx;
    logic [packet_pkg::CNT_WID-1:0] delivered;
    logic [packet_pkg::CNT_WID-1:0] drops_expected;

    task automatic compare_beat(input packet_pkg::packet_beat_t exp_b,
                                input packet_pkg::packet_beat_t got_b);
        if (got_b.data !== exp_b.data) begin
            beat_errors = beat_errors + 1;
            $display("FAILED out_beat.data: packet %0d beat %0d, expected %h, got %h",
                     delivered, out_beat_idx, exp_b.data, got_b.data);
        end
        if (got_b.eop !== exp_b.eop) begin
            beat_errors = beat_errors + 1;
            $display("FAILED out_beat.eop: packet %0d beat %0d, expected %h, got %h",
                     delivered, out_beat_idx, exp_b.eop, got_b.eop);
        end
        if (got_b.mty !== exp_b.mty) begin
            beat_errors = beat_errors + 1;
            $display("FAILED out_beat.mty: packet %0d beat %0d, expected %h, got %h",
                     delivered, out_beat_idx, exp_b.mty, got_b.mty);
        end
        if (got_b.err !== exp_b.err) begin
            beat_errors = beat_errors + 1;
            $display("FAILED out_beat.err: packet %0d beat %0d, expected %h, got %h",
                     delivered, out_beat_idx, exp_b.err, got_b.err);
        end
        if (got_b.meta !== exp_b.meta) begin
            beat_errors = beat_errors + 1;
            $display("FAILED out_beat.meta: packet %0d beat %0d, expected %h, got %h",
                     delivered, out_beat_idx, exp_b.meta, got_b.meta);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            cur_pkt.delete();
            stalled = 1'b0;
            counters_checked = 1'b0;
            occupancy = 0;
            out_beat_idx = 0;
            delivered = '0;
            drops_expected = '0;
            beat_errors = 0;
            count_errors = 0;
            other_errors = 0;
            pending_beats <= 0;
        end else begin
            // ==================================================
            // Output must hold while stalled
            // ==================================================
            if (stalled) begin
                if (!out_valid) begin
                    other_errors = other_errors + 1;
                    $display("Output valid was withdrawn while the output was stalled");
                end else if (out_beat !== held_beat) begin
                    beat_errors = beat_errors + 1;
                    $display("FAILED out_beat changed while stalled: expected %h, got %h",
                             held_beat, out_beat);
                end
            end
            stalled = out_valid && !out_ready;
            held_beat = out_beat;

            // ==================================================
            // Output transfers
            // ==================================================
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors = other_errors + 1;
                    $display("Beat left the output while no packet was owed");
                end else begin
                    exp_beat = exp_q.pop_front();
                    compare_beat(exp_beat, out_beat);
                    occupancy = occupancy - 1;
                    if (exp_beat.eop) begin
                        delivered = delivered + 1'b1;
                        out_beat_idx = 0;
                    end else begin
                        out_beat_idx = out_beat_idx + 1;
                    end
                end
            end

            // ==================================================
            // Input transfers and the drop rule
            // ==================================================
            if (in_valid && in_ready) begin
                cur_pkt.push_back(in_beat);
                if (in_beat.eop) begin
                    // Bad packets and packets larger than the free space vanish
                    if (in_beat.err ||
                        occupancy + cur_pkt.size() > packet_pkg::FIFO_DEPTH) begin
                        drops_expected = drops_expected + 1'b1;
                    end else begin
                        foreach (cur_pkt[i]) begin
                            exp_q.push_back(cur_pkt[i]);
                        end
                        occupancy = occupancy + cur_pkt.size();
                    end
                    cur_pkt.delete();
                end
            end

            // End of run
            if (check_counters && !counters_checked) begin
                counters_checked = 1'b1;
                if (pkt_count !== delivered) begin
                    count_errors = count_errors + 1;
                    $display("FAILED pkt_count: expected %h, got %h", delivered, pkt_count);
                end
                if (drop_count !== drops_expected) begin
                    count_errors = count_errors + 1;
                    $display("FAILED drop_count: expected %h, got %h",
                             drops_expected, drop_count);
                end
            end

            pending_beats <= occupancy;
        end
    end

endmodule

`default_nettype wire

/* test/packet_buffer_top_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module packet_buffer_top_tb;

    localparam int NUM_PKTS = 12;
    // Headroom left free when pacing packets in
    localparam int FILL_MARGIN = 4;

    typedef struct packed {
        int   len;
        logic err;
        int   stall_pct;
        int   ready_pct;
    } pkt_entry_t;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    packet_pkg::packet_beat_t in_beat;
    logic out_valid;
    logic out_ready = 1'b0;
    packet_pkg::packet_beat_t out_beat;
    logic [packet_pkg::CNT_WID-1:0] pkt_count;
    logic [packet_pkg::CNT_WID-1:0] drop_count;

    logic check_counters;
    int   pending_beats;
    int   beat_errors;
    int   count_errors;
    int   other_errors;

    pkt_entry_t pkt_table [NUM_PKTS];

    integer seed = 87;
    integer ready_seed = 87;
    int     ready_pct;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    // ==================================================
    // DUT and checker
    // ==================================================
    packet_buffer_top packet_buffer_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat),
        .pkt_count  (pkt_count),
        .drop_count (drop_count)
    );

    packet_buffer_checker checker_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_beat        (in_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_beat       (out_beat),
        .pkt_count      (pkt_count),
        .drop_count     (drop_count),
        .check_counters (check_counters),
        .pending_beats  (pending_beats),
        .beat_errors    (beat_errors),
        .count_errors   (count_errors),
        .other_errors   (other_errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Random output back-pressure
    always @(posedge clk) begin
        if (!rst_n) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= ($unsigned($random(ready_seed)) % 100) < ready_pct;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Length in bytes, err flag, input stall %, output ready %
    task automatic load_table();
        pkt_table[0]  = '{8,   1'b0, 0,  100};
        pkt_table[1]  = '{64,  1'b0, 0,  100};
        pkt_table[2]  = '{100, 1'b0, 20, 100};
        pkt_table[3]  = '{37,  1'b0, 25, 100};
        pkt_table[4]  = '{250, 1'b0, 10, 50};
        pkt_table[5]  = '{5,   1'b1, 0,  50};
        pkt_table[6]  = '{180, 1'b0, 30, 50};
        pkt_table[7]  = '{73,  1'b0, 15, 50};
        pkt_table[8]  = '{320, 1'b0, 20, 70};
        // Oversize packet of 75 beats
        pkt_table[9]  = '{600, 1'b0, 0,  100};
        pkt_table[10] = '{16,  1'b0, 10, 100};
        pkt_table[11] = '{200, 1'b0, 25, 60};
    endtask

    function automatic int table_beats();
        int sum;
        sum = 0;
        foreach (pkt_table[i]) begin
            sum += (pkt_table[i].len + 7) / 8;
        end
        return sum;
    endfunction

    task automatic send_packet(input pkt_entry_t entry);
        int beats;
        int b;
        packet_pkg::packet_beat_t beat;
        beats = (entry.len + 7) / 8;

        // Wait for room unless the packet is oversize
        in_valid <= 1'b0;
        @(posedge clk);
        while (beats <= packet_pkg::FIFO_DEPTH &&
               pending_beats + beats > packet_pkg::FIFO_DEPTH - FILL_MARGIN) begin
            @(posedge clk);
        end
        ready_pct <= entry.ready_pct;

        for (b = 0; b < beats; b++) begin
            while (($unsigned($random(seed)) % 100) < entry.stall_pct) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            beat = '0;
            beat.data[63:32] = $random(seed);
            beat.data[31:0] = $random(seed);
            if (b == beats - 1) begin
                beat.eop = 1'b1;
                beat.mty = 3'(beats * 8 - entry.len);
                beat.err = entry.err;
                beat.meta = $random(seed);
            end
            in_valid <= 1'b1;
            in_beat <= beat;
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_beat = '0;
        check_counters = 1'b0;
        ready_pct = 100;
        load_table();
        cycle_limit = table_beats() * 4 + 2000;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        foreach (pkt_table[p]) begin
            send_packet(pkt_table[p]);
        end

        // Drain everything still owed
        @(posedge clk);
        while (pending_beats != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        check_counters <= 1'b1;
        repeat (3) @(posedge clk);

        $display("Error counts: beat %0d, counter %0d, other %0d",
                 beat_errors, count_errors, other_errors);
        if (beat_errors + count_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* packet_buffer_top.f */
hw/packet_pkg.sv
hw/packet_intf_connector.sv
hw/packet_fifo_mem.sv
hw/packet_fifo.sv
hw/packet_buffer_top.sv
test/packet_buffer_checker.sv
test/packet_buffer_top_tb.sv

/* Makefile */
TOOL       := verilator
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall
TOP        := packet_buffer_top_tb
RTL_TOP    := packet_buffer_top
FILELIST   := packet_buffer_top.f
OBJ_DIR    := obj_dir
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
